//--- src/fieldPkg.sv
`default_nettype none

package fieldPkg;

   // Playfield geometry in pixels
   localparam int fieldWidth = 640;
   localparam int numRows = 4;
   localparam int padsPerRow = 4;
   localparam int padWidth = 48;
   localparam int rowHeight = 40;

   typedef logic [10:0] coordT;

   // Per-row pad configuration, index 0 is the row nearest the far bank
   localparam int rowGap [0:numRows-1] = '{80, 80, 80, 80};

   localparam int rowSpeed [0:numRows-1] = '{25, 25, 25, 25};

   // Alternating drift direction
   localparam bit rowDirRight [0:numRows-1] = '{1'b1, 1'b0, 1'b1, 1'b0};

   localparam coordT rowStartY [0:numRows-1] = '{
      11'd320,
      11'd360,
      11'd400,
      11'd440
   };

   // X positions of all pads in one row
   typedef struct packed {
      coordT [padsPerRow-1:0] x;
   } padRowT;

endpackage

`default_nettype wire

//--- src/frogPkg.sv
`default_nettype none

package frogPkg;

   import fieldPkg::coordT;

   // Start bank and far bank
   localparam coordT frogStartX = 11'd320;
   localparam coordT frogStartY = 11'd480;
   localparam coordT goalY = 11'd280;

   // Horizontal step and right-hand limit
   localparam coordT frogStepX = 11'd16;
   localparam coordT frogMaxX = 11'd624;

   typedef struct packed {
      coordT x;
      coordT y;
   } frogPosT;

   // One-cycle key strobes
   typedef struct packed {
      logic up;
      logic down;
      logic left;
      logic right;
   } moveT;

   typedef struct packed {
      logic crossed;
      logic drowned;
   } frogEventT;

   typedef logic [7:0] countT;

endpackage

`default_nettype wire

//--- src/lilypadRow.sv
`timescale 1ns/1ps
`default_nettype none

module lilypadRow
   import fieldPkg::*;
   import frogPkg::*;
#(
   parameter int rowIdx = 0
) (
   input  logic    frameClk,
   input  logic    rstN,
   input  frogPosT frogPos,
   output padRowT  padPos,
   output logic    onPad
);

   // Constants of this row
   localparam coordT padPitch = coordT'(padWidth + rowGap[rowIdx]);
   localparam coordT speed = coordT'(rowSpeed[rowIdx]);
   localparam coordT wrap = coordT'(fieldWidth);
   localparam coordT padW = coordT'(padWidth);
   localparam bit dirRight = rowDirRight[rowIdx];
   localparam coordT rowY = rowStartY[rowIdx];

   coordT [padsPerRow-1:0] padNext;
   logic [padsPerRow-1:0] padHit;
   coordT [padsPerRow-1:0] frogOffset;

   // Next pad positions with wraparound at the field edge
   always_comb begin
      for (int k = 0; k < padsPerRow; k++) begin
         if (dirRight) begin
            if (padPos.x[k] + speed >= wrap) begin
               padNext[k] = padPos.x[k] + speed - wrap;
            end else begin
               padNext[k] = padPos.x[k] + speed;
            end
         end else begin
            if (padPos.x[k] >= speed) begin
               padNext[k] = padPos.x[k] - speed;
            end else begin
               padNext[k] = padPos.x[k] + wrap - speed;
            end
         end
      end
   end

   always_ff @(posedge frameClk) begin
      if (!rstN) begin
         for (int k = 0; k < padsPerRow; k++) begin
            padPos.x[k] <= coordT'(k) * padPitch;
         end
      end else begin
         padPos.x <= padNext;
      end
   end

   // Frog X relative to each pad, taken modulo the field width
   always_comb begin
      for (int k = 0; k < padsPerRow; k++) begin
         if (frogPos.x >= padPos.x[k]) begin
            frogOffset[k] = frogPos.x - padPos.x[k];
         end else begin
            frogOffset[k] = frogPos.x + wrap - padPos.x[k];
         end
         padHit[k] = frogOffset[k] < padW;
      end
   end

   // Only meaningful while the frog sits in this row
   assign onPad = (frogPos.y == rowY) && (|padHit);

endmodule

`default_nettype wire

//--- src/frogMotion.sv
`timescale 1ns/1ps
`default_nettype none

module frogMotion
   import fieldPkg::*;
   import frogPkg::*;
(
   input  logic               frameClk,
   input  logic               rstN,
   input  moveT               move,
   input  logic [numRows-1:0] onPad,
   output frogPosT            frogPos,
   output frogEventT          frogEvent
);

   localparam frogPosT startPos = '{x: frogStartX, y: frogStartY};
   localparam coordT stepY = coordT'(rowHeight);

   frogPosT posNext;
   frogEventT eventNext;
   logic inRiver;
   logic riding;
   coordT rideX;
   coordT upY;
   coordT downY;

   // Which river row holds the frog, and where that row would carry it
   always_comb begin
      inRiver = 1'b0;
      riding = 1'b0;
      rideX = frogPos.x;
      for (int r = 0; r < numRows; r++) begin
         if (frogPos.y == rowStartY[r]) begin
            inRiver = 1'b1;
            riding = onPad[r];
            if (rowDirRight[r]) begin
               if (frogPos.x + coordT'(rowSpeed[r]) > frogMaxX) begin
                  rideX = frogMaxX;
               end else begin
                  rideX = frogPos.x + coordT'(rowSpeed[r]);
               end
            end else begin
               if (frogPos.x < coordT'(rowSpeed[r])) begin
                  rideX = '0;
               end else begin
                  rideX = frogPos.x - coordT'(rowSpeed[r]);
               end
            end
         end
      end
   end

   assign upY = frogPos.y - stepY;
   assign downY = frogPos.y + stepY;

   // Moves win over riding; priority is up, down, left, right
   always_comb begin
      posNext = frogPos;
      eventNext = '0;
      if (move.up) begin
         if (upY == goalY) begin
            posNext = startPos;
            eventNext.crossed = 1'b1;
         end else begin
            posNext.y = upY;
         end
      end else if (move.down) begin
         posNext.y = (downY > frogStartY) ? frogStartY : downY;
      end else if (move.left) begin
         posNext.x = (frogPos.x < frogStepX) ? '0 : frogPos.x - frogStepX;
      end else if (move.right) begin
         posNext.x = (frogPos.x + frogStepX > frogMaxX) ? frogMaxX : frogPos.x + frogStepX;
      end else if (inRiver) begin
         if (riding) begin
            posNext.x = rideX;
         end else begin
            // Missed every pad
            posNext = startPos;
            eventNext.drowned = 1'b1;
         end
      end
   end

   always_ff @(posedge frameClk) begin
      if (!rstN) begin
         frogPos <= startPos;
         frogEvent <= '0;
      end else begin
         frogPos <= posNext;
         frogEvent <= eventNext;
      end
   end

endmodule

`default_nettype wire

//--- src/scoreKeeper.sv
`timescale 1ns/1ps
`default_nettype none

module scoreKeeper
   import frogPkg::*;
(
   input  logic      frameClk,
   input  logic      rstN,
   input  frogEventT frogEvent,
   output countT     crossings,
   output countT     drownings
);

   localparam countT countMax = '1;

   always_ff @(posedge frameClk) begin
      if (!rstN) begin
         crossings <= '0;
         drownings <= '0;
      end else begin
         // Both counters stick at their maximum
         if (frogEvent.crossed && crossings != countMax) begin
            crossings <= crossings + countT'(1);
         end
         if (frogEvent.drowned && drownings != countMax) begin
            drownings <= drownings + countT'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- src/frogRiver.sv
`timescale 1ns/1ps
`default_nettype none

module frogRiver
   import fieldPkg::*;
   import frogPkg::*;
(
   input  logic      frameClk,
   input  logic      rstN,
   input  moveT      move,
   output padRowT    padX [numRows],
   output frogPosT   frogPos,
   output frogEventT frogEvent,
   output countT     crossings,
   output countT     drownings
);

   logic [numRows-1:0] onPad;

   // One instance per river row
   for (genvar r = 0; r < numRows; r++) begin : rowGen
      lilypadRow #(
         .rowIdx(r)
      ) padRow (
         .frameClk(frameClk),
         .rstN(rstN),
         .frogPos(frogPos),
         .padPos(padX[r]),
         .onPad(onPad[r])
      );
   end

   frogMotion motion (
      .frameClk(frameClk),
      .rstN(rstN),
      .move(move),
      .onPad(onPad),
      .frogPos(frogPos),
      .frogEvent(frogEvent)
   );

   scoreKeeper score (
      .frameClk(frameClk),
      .rstN(rstN),
      .frogEvent(frogEvent),
      .crossings(crossings),
      .drownings(drownings)
   );

endmodule

`default_nettype wire

//--- verif/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
   parameter int resetCycles = 5
) (
   output logic frameClk,
   output logic rstN
);

   // One frame every 100 ns
   initial begin
      frameClk = 1'b0;
      forever #50 frameClk = ~frameClk;
   end

   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge frameClk);
      rstN <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/frogRiverTb.sv
`timescale 1ns/1ps
`default_nettype none

module frogRiverTb
   import fieldPkg::*;
   import frogPkg::*;
();

   localparam string inputPath = "verif/frogRiverInput.txt";
   localparam int resetCycles = 5;

   logic frameClk;
   logic rstN;
   moveT move;
   padRowT padX [numRows];
   frogPosT frogPos;
   frogEventT frogEvent;
   countT crossings;
   countT drownings;

   // One entry per data line of the input file
   moveT stepMove [$];
   int stepIdle [$];
   frogPosT stepFrog [$];
   countT stepCross [$];
   countT stepDrown [$];

   // Event strobes seen since reset
   countT crossStrobes;
   countT drownStrobes;

   int frameCnt = 0;
   int padErrors = 0;
   int frogErrors = 0;
   int eventErrors = 0;
   int countErrors = 0;
   int inputErrors = 0;
   int limitCycles = 0;
   logic loadDone = 1'b0;

   clockGen #(.resetCycles(resetCycles)) clkGen (
      .frameClk(frameClk),
      .rstN(rstN)
   );

   frogRiver dut_i (
      .frameClk(frameClk),
      .rstN(rstN),
      .move(move),
      .padX(padX),
      .frogPos(frogPos),
      .frogEvent(frogEvent),
      .crossings(crossings),
      .drownings(drownings)
   );

   task automatic checkPadRow(input string name, input padRowT expected, input padRowT actual);
      if (actual !== expected) begin
         padErrors++;
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic checkFrog(input string name, input frogPosT expected, input frogPosT actual);
      if (actual !== expected) begin
         frogErrors++;
         $display("[FAIL] %s expected (%0d, %0d) actual (%0d, %0d)", name,
            expected.x, expected.y, actual.x, actual.y);
      end
   endtask

   task automatic checkEvent(input string name, input frogEventT expected,
      input frogEventT actual);
      if (actual !== expected) begin
         eventErrors++;
         $display("[FAIL] %s expected crossed %b drowned %b actual crossed %b drowned %b",
            name, expected.crossed, expected.drowned, actual.crossed, actual.drowned);
      end
   endtask

   task automatic checkCount(input string name, input countT expected, input countT actual);
      if (actual !== expected) begin
         countErrors++;
         $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
      end
   endtask

   // Start X plus or minus n steps of the row speed, wrapped to the field
   function automatic padRowT expectedPads(input int r, input int n);
      padRowT model;
      int pos;
      for (int k = 0; k < padsPerRow; k++) begin
         pos = k * (padWidth + rowGap[r]);
         pos = rowDirRight[r] ? pos + n * rowSpeed[r] : pos - n * rowSpeed[r];
         pos = ((pos % fieldWidth) + fieldWidth) % fieldWidth;
         model.x[k] = coordT'(pos);
      end
      return model;
   endfunction

   // Frames since reset was released, same count as the pad registers see
   always @(posedge frameClk) begin
      if (!rstN) begin
         frameCnt <= 0;
      end else begin
         frameCnt <= frameCnt + 1;
      end
   end

   // A strobe is counted on the edge after it appears
   always @(posedge frameClk) begin
      if (!rstN) begin
         crossStrobes <= '0;
         drownStrobes <= '0;
      end else begin
         if (frogEvent.crossed) begin
            crossStrobes <= crossStrobes + countT'(1);
         end
         if (frogEvent.drowned) begin
            drownStrobes <= drownStrobes + countT'(1);
         end
      end
   end

   always @(negedge frameClk) begin
      if (rstN === 1'b1) begin
         for (int r = 0; r < numRows; r++) begin
            checkPadRow($sformatf("frame %0d row %0d pads", frameCnt, r),
               expectedPads(r, frameCnt), padX[r]);
         end
      end
   end

   task automatic readStimulus();
      int fd;
      int got;
      int lineNo;
      int idle;
      int fx;
      int fy;
      int nCross;
      int nDrown;
      string text;
      logic [47:0] name;
      moveT cmd;
      frogPosT pos;
      lineNo = 0;
      fd = $fopen(inputPath, "r");
      if (fd == 0) begin
         inputErrors++;
         $display("could not open the input file %s", inputPath);
         return;
      end
      while (!$feof(fd)) begin
         text = "";
         got = $fgets(text, fd);
         lineNo++;
         // Skip comments and blank lines
         if (got == 0 || text.len() < 2 || text[0] == "#") begin
            continue;
         end
         got = $sscanf(text, "%s %d %d %d %d %d", name, idle, fx, fy, nCross, nDrown);
         if (got != 6) begin
            inputErrors++;
            $display("input line %0d is malformed, only %0d of 6 fields read", lineNo, got);
            continue;
         end
         cmd = '0;
         case (name)
            48'("none"): cmd = '0;
            48'("up"): cmd.up = 1'b1;
            48'("down"): cmd.down = 1'b1;
            48'("left"): cmd.left = 1'b1;
            48'("right"): cmd.right = 1'b1;
            default: begin
               inputErrors++;
               $display("input line %0d has an unknown move code", lineNo);
               continue;
            end
         endcase
         pos.x = coordT'(fx);
         pos.y = coordT'(fy);
         stepMove.push_back(cmd);
         stepIdle.push_back(idle);
         stepFrog.push_back(pos);
         stepCross.push_back(countT'(nCross));
         stepDrown.push_back(countT'(nDrown));
      end
      $fclose(fd);
      if (stepMove.size() == 0) begin
         inputErrors++;
         $display("the input file holds no steps");
      end
   endtask

   // Move strobe for one frame, then the idle frames, then compare
   task automatic applyStep(input int i);
      string name;
      name = $sformatf("step %0d", i + 1);
      @(posedge frameClk);
      move <= stepMove[i];
      @(posedge frameClk);
      move <= '0;
      repeat (stepIdle[i]) @(posedge frameClk);
      @(negedge frameClk);
      checkFrog({name, " frog"}, stepFrog[i], frogPos);
      checkCount({name, " crossings"}, stepCross[i], crossings);
      checkCount({name, " drownings"}, stepDrown[i], drownings);
      checkCount({name, " crossed strobes"}, stepCross[i], crossStrobes);
      checkCount({name, " drowned strobes"}, stepDrown[i], drownStrobes);
   endtask

   initial begin
      frogPosT startPos;
      move = '0;
      startPos.x = frogStartX;
      startPos.y = frogStartY;
      readStimulus();
      limitCycles = 2 * resetCycles;
      foreach (stepIdle[i]) begin
         limitCycles += stepIdle[i] + 10;
      end
      loadDone = 1'b1;
      wait (rstN === 1'b1);
      @(negedge frameClk);
      checkFrog("after reset frog", startPos, frogPos);
      checkEvent("after reset strobes", frogEventT'(0), frogEvent);
      checkCount("after reset crossings", countT'(0), crossings);
      checkCount("after reset drownings", countT'(0), drownings);
      foreach (stepMove[i]) begin
         applyStep(i);
      end
      $display("errors: pads %0d, frog %0d, events %0d, counts %0d, input %0d",
         padErrors, frogErrors, eventErrors, countErrors, inputErrors);
      if (padErrors + frogErrors + eventErrors + countErrors + inputErrors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Watchdog sized from the idle frames of all steps
   initial begin
      wait (loadDone === 1'b1);
      repeat (limitCycles) @(posedge frameClk);
      $display("timeout after %0d frames, the steps did not complete", limitCycles);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
src/fieldPkg.sv
src/frogPkg.sv
src/lilypadRow.sv
src/frogMotion.sv
src/scoreKeeper.sv
src/frogRiver.sv
verif/clockGen.sv
verif/frogRiverTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module frogRiverTb -o frogRiverSim \
   && ./obj_dir/frogRiverSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

//--- verif/frogRiverInput.txt
# move idle frogX frogY crossings drownings
# expected values hold after the move frame and the idle frames
none  2 320 480 0 0
left  0 304 480 0 0
right 0 320 480 0 0
right 1 336 480 0 0
down  0 336 480 0 0
up    2 320 480 0 1
up    3 245 440 0 1
none  6  45 440 0 1
left  0   4 440 0 1
left  0   0 440 0 1
none  1 320 480 0 2
up    0 320 440 0 2
none  1 245 440 0 2
up    0 220 400 0 2
none  1 295 400 0 2
up    0 320 360 0 2
up    0 295 320 0 2
none 10 595 320 0 2
right 0 624 320 0 2
up    2 320 480 1 2
down  0 320 480 1 2
